//--- axi_arb.f
+incdir+common
common/axi_arb_pkg.sv
arbiter/grant_fsm.sv
router/read_router.sv
router/write_router.sv
logic/axi_arb_top.sv
tests/tb_slave.sv
tests/axi_arb_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the AXI-lite arbiter testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f axi_arb.f \
    --top-module axi_arb_tb \
    -o axi_arb_sim

./obj_dir/axi_arb_sim

//--- tests/axi_arb_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_arb_settings.svh"

module axi_arb_tb;
    import axi_arb_pkg::*;

    localparam int TIMEOUT = 1000;  // Cycles per transaction, grant wait included

    logic                   clk;
    logic                   reset;
    logic [`AXI_ADDR_W-1:0] ifu_araddr, lsu_araddr, lsu_awaddr;
    logic [`AXI_ADDR_W-1:0] sram_araddr, sram_awaddr, uart_araddr, uart_awaddr;
    logic [`AXI_DATA_W-1:0] ifu_rdata, lsu_rdata, lsu_wdata;
    logic [`AXI_DATA_W-1:0] sram_rdata, sram_wdata, uart_rdata, uart_wdata;
    logic [`AXI_STRB_W-1:0] lsu_wstrb, sram_wstrb, uart_wstrb;
    logic [1:0]             ifu_rresp, lsu_rresp, lsu_bresp;
    logic [1:0]             sram_rresp, sram_bresp, uart_rresp, uart_bresp;
    logic                   ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
    logic                   lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
    logic                   lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready;
    logic                   lsu_bvalid, lsu_bready;
    logic                   sram_arvalid, sram_arready, sram_rvalid, sram_rready;
    logic                   sram_awvalid, sram_awready, sram_wvalid, sram_wready;
    logic                   sram_bvalid, sram_bready;
    logic                   uart_arvalid, uart_arready, uart_rvalid, uart_rready;
    logic                   uart_awvalid, uart_awready, uart_wvalid, uart_wready;
    logic                   uart_bvalid, uart_bready;
    logic                   touch_clear, sram_touched, uart_touched;
    integer                 seed;
    int                     finish_count;
    int                     rank_wr, rank_rd, rank_ifu;
    logic [`AXI_DATA_W-1:0] shadow [logic [`AXI_ADDR_W-3:0]];  // Word model, both windows

    axi_arb_top axi_arb_top_i (.*);

    tb_slave #(.IS_UART(1'b0)) sram_model (
        .clk, .reset,
        .araddr(sram_araddr), .arvalid(sram_arvalid), .arready(sram_arready),
        .rdata(sram_rdata), .rresp(sram_rresp), .rvalid(sram_rvalid), .rready(sram_rready),
        .awaddr(sram_awaddr), .awvalid(sram_awvalid), .awready(sram_awready),
        .wdata(sram_wdata), .wstrb(sram_wstrb), .wvalid(sram_wvalid), .wready(sram_wready),
        .bresp(sram_bresp), .bvalid(sram_bvalid), .bready(sram_bready),
        .touch_clear, .touched(sram_touched)
    );

    tb_slave #(.IS_UART(1'b1)) uart_model (
        .clk, .reset,
        .araddr(uart_araddr), .arvalid(uart_arvalid), .arready(uart_arready),
        .rdata(uart_rdata), .rresp(uart_rresp), .rvalid(uart_rvalid), .rready(uart_rready),
        .awaddr(uart_awaddr), .awvalid(uart_awvalid), .awready(uart_awready),
        .wdata(uart_wdata), .wstrb(uart_wstrb), .wvalid(uart_wvalid), .wready(uart_wready),
        .bresp(uart_bresp), .bvalid(uart_bvalid), .bready(uart_bready),
        .touch_clear, .touched(uart_touched)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string msg);
        stop_run($sformatf("Mismatch at %0t: %s", $time, msg));
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic random_ready();
        return ($random(seed) & 3) != 0;  // Ready three cycles in four
    endfunction

    function automatic logic [`AXI_ADDR_W-1:0] sram_addr(input int idx);
        return `SRAM_BASE + 32'(idx << 2);
    endfunction

    function automatic logic [1:0] expect_resp(input logic [`AXI_ADDR_W-1:0] addr,
                                               input bit is_write);
        if (addr >= `SRAM_BASE && addr <= `SRAM_LAST) begin
            return RESP_OKAY;
        end
        if (addr >= `UART_BASE && addr <= `UART_LAST) begin
            return (is_write && addr[2]) ? RESP_SLVERR : RESP_OKAY;
        end
        return RESP_DECERR;
    endfunction

    function automatic logic [`AXI_DATA_W-1:0] expect_data(input logic [`AXI_ADDR_W-1:0] addr);
        if (expect_resp(addr, 1'b0) == RESP_DECERR) begin
            return '0;
        end
        if (shadow.exists(addr[`AXI_ADDR_W-1:2])) begin
            return shadow[addr[`AXI_ADDR_W-1:2]];
        end
        return {addr[`AXI_ADDR_W-1:2], 2'b00} ^ 32'h3c5a_96e1;  // Subordinate fill value
    endfunction

    function automatic logic [`AXI_DATA_W-1:0] merge_bytes(input logic [`AXI_DATA_W-1:0] old,
            input logic [`AXI_DATA_W-1:0] data, input logic [`AXI_STRB_W-1:0] strb);
        logic [`AXI_DATA_W-1:0] result;
        result = old;
        for (int i = 0; i < `AXI_STRB_W; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = data[8*i +: 8];
            end
        end
        return result;
    endfunction

    // Samples at the falling edge, drives 1 ns after the rising edge
    task automatic read_txn(input bit from_ifu, input logic [`AXI_ADDR_W-1:0] addr);
        logic [`AXI_DATA_W-1:0] exp_data, data, held_data;
        logic [1:0]             exp_resp, resp, held_resp;
        logic                   arv, ardy, vld, rdy, ar_hs, r_hs, stalled;
        int                     cycles;
        exp_resp = expect_resp(addr, 1'b0);
        exp_data = expect_data(addr);
        if (from_ifu) begin
            ifu_araddr  = addr;
            ifu_arvalid = 1'b1;
            ifu_rready  = random_ready();
        end else begin
            lsu_araddr  = addr;
            lsu_arvalid = 1'b1;
            lsu_rready  = random_ready();
        end
        cycles  = 0;
        stalled = 1'b0;
        r_hs    = 1'b0;
        while (!r_hs) begin
            @(negedge clk);
            arv  = from_ifu ? ifu_arvalid : lsu_arvalid;
            ardy = from_ifu ? ifu_arready : lsu_arready;
            vld  = from_ifu ? ifu_rvalid : lsu_rvalid;
            rdy  = from_ifu ? ifu_rready : lsu_rready;
            data = from_ifu ? ifu_rdata : lsu_rdata;
            resp = from_ifu ? ifu_rresp : lsu_rresp;
            if (stalled) begin
                assert (vld && data == held_data && resp == held_resp)
                    else mismatch($sformatf("R channel of %h changed while stalled", addr));
            end
            stalled   = vld && !rdy;
            held_data = data;
            held_resp = resp;
            ar_hs     = arv && ardy;
            r_hs      = vld && rdy;
            @(posedge clk);
            #1;
            if (from_ifu) begin
                if (ar_hs) ifu_arvalid = 1'b0;
                ifu_rready = r_hs ? 1'b0 : random_ready();
            end else begin
                if (ar_hs) lsu_arvalid = 1'b0;
                lsu_rready = r_hs ? 1'b0 : random_ready();
            end
            cycles++;
            if (!r_hs && cycles > TIMEOUT) begin
                stop_run($sformatf("Timeout: no read response for %s at %h",
                                   from_ifu ? "IFU" : "LSU", addr));
            end
        end
        assert (data == exp_data && resp == exp_resp)
            else mismatch($sformatf("%s read %h gave %h resp %0d, expected %h resp %0d",
                from_ifu ? "IFU" : "LSU", addr, data, resp, exp_data, exp_resp));
    endtask

    task automatic write_txn(input logic [`AXI_ADDR_W-1:0] addr,
                             input logic [`AXI_DATA_W-1:0] data,
                             input logic [`AXI_STRB_W-1:0] strb);
        logic [1:0] exp_resp, resp, held_resp;
        logic       aw_hs, w_hs, b_hs, stalled;
        int         cycles;
        exp_resp    = expect_resp(addr, 1'b1);
        lsu_awaddr  = addr;
        lsu_awvalid = 1'b1;
        lsu_wdata   = data;
        lsu_wstrb   = strb;
        lsu_wvalid  = 1'b1;
        lsu_bready  = random_ready();
        cycles      = 0;
        stalled     = 1'b0;
        b_hs        = 1'b0;
        while (!b_hs) begin
            @(negedge clk);
            if (stalled) begin
                assert (lsu_bvalid && lsu_bresp == held_resp)
                    else mismatch($sformatf("B channel of %h changed while stalled", addr));
            end
            stalled   = lsu_bvalid && !lsu_bready;
            held_resp = lsu_bresp;
            resp      = lsu_bresp;
            aw_hs     = lsu_awvalid && lsu_awready;
            w_hs      = lsu_wvalid && lsu_wready;
            b_hs      = lsu_bvalid && lsu_bready;
            @(posedge clk);
            #1;
            if (aw_hs) lsu_awvalid = 1'b0;
            if (w_hs) lsu_wvalid = 1'b0;
            lsu_bready = b_hs ? 1'b0 : random_ready();
            cycles++;
            if (!b_hs && cycles > TIMEOUT) begin
                stop_run($sformatf("Timeout: no write response for LSU at %h", addr));
            end
        end
        assert (resp == exp_resp)
            else mismatch($sformatf("write %h gave resp %0d, expected %0d", addr, resp, exp_resp));
        if (exp_resp == RESP_OKAY) begin
            shadow[addr[`AXI_ADDR_W-1:2]] = merge_bytes(expect_data(addr), data, strb);
        end
    endtask

    task automatic unmapped_txns(input logic [`AXI_ADDR_W-1:0] addr);
        touch_clear = 1'b1;
        @(posedge clk);
        #1;
        touch_clear = 1'b0;
        write_txn(addr, rand_word(), 4'hf);
        read_txn(1'b0, addr);
        read_txn(1'b1, addr);
        assert (!sram_touched && !uart_touched)
            else stop_run($sformatf("A subordinate saw a valid for unmapped address %h", addr));
    endtask

    initial begin
        logic [`AXI_ADDR_W-1:0] addr;
        seed        = 32'hffca_69fc;
        reset       = 1'b1;
        ifu_araddr  = '0;
        ifu_arvalid = 1'b0;
        ifu_rready  = 1'b0;
        lsu_araddr  = '0;
        lsu_arvalid = 1'b0;
        lsu_rready  = 1'b0;
        lsu_awaddr  = '0;
        lsu_awvalid = 1'b0;
        lsu_wdata   = '0;
        lsu_wstrb   = '0;
        lsu_wvalid  = 1'b0;
        lsu_bready  = 1'b0;
        touch_clear = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // SRAM fill with random strobes, then LSU read back
        for (int i = 0; i < 128; i++) begin
            write_txn(sram_addr(i), rand_word(), 4'(rand_word()));
        end
        for (int i = 0; i < 64; i++) begin
            read_txn(1'b0, sram_addr(int'(rand_word() & 32'd127)));
        end

        // IFU fetches from the upper half while the LSU works on the lower half
        fork
            for (int i = 0; i < 40; i++) begin
                read_txn(1'b1, sram_addr(64 + int'(rand_word() & 32'd63)));
            end
            for (int i = 0; i < 40; i++) begin
                addr = sram_addr(int'(rand_word() & 32'd63));
                write_txn(addr, rand_word(), 4'(rand_word()));
                read_txn(1'b0, addr);
                @(posedge clk);  // Idle gap lets the IFU win a grant
                #1;
            end
        join

        // UART data round trip, then the read-only status register
        for (int i = 0; i < 8; i++) begin
            write_txn(`UART_BASE, rand_word(), 4'hf);
            read_txn(1'b0, `UART_BASE);
        end
        write_txn(`UART_BASE + 32'd4, rand_word(), 4'hf);
        read_txn(1'b0, `UART_BASE + 32'd4);
        read_txn(1'b1, `UART_BASE + 32'd4);

        unmapped_txns(32'h8800_0000);
        unmapped_txns(32'ha000_0008);
        for (int i = 0; i < 8; i++) begin
            addr = rand_word() & 32'hffff_fffc;
            if (expect_resp(addr, 1'b0) != RESP_DECERR) begin
                addr = addr ^ 32'h4000_0000;  // Moves either window into a hole
            end
            unmapped_txns(addr);
        end

        // All three requests raised in the same cycle on an idle bus
        for (int j = 0; j < 4; j++) begin
            finish_count = 0;
            fork
                begin
                    write_txn(sram_addr(200 + 3 * j), rand_word(), 4'hf);
                    finish_count += 1;
                    rank_wr = finish_count;
                end
                begin
                    read_txn(1'b0, sram_addr(201 + 3 * j));
                    finish_count += 1;
                    rank_rd = finish_count;
                end
                begin
                    read_txn(1'b1, sram_addr(202 + 3 * j));
                    finish_count += 1;
                    rank_ifu = finish_count;
                end
            join
            assert (rank_wr == 1 && rank_rd == 2 && rank_ifu == 3)
                else mismatch($sformatf("completion order write %0d, LSU read %0d, IFU read %0d",
                    rank_wr, rank_rd, rank_ifu));
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_slave.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_arb_settings.svh"

module tb_slave #(
    parameter bit IS_UART = 1'b0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [`AXI_DATA_W-1:0] rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`AXI_DATA_W-1:0] wdata,
    input  logic [`AXI_STRB_W-1:0] wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic                   touch_clear,
    output logic                   touched
);
    import axi_arb_pkg::*;

    localparam logic [2:0] STATUS_OFS = 3'd4;  // UART status, read only

    logic [`AXI_DATA_W-1:0] mem [logic [`AXI_ADDR_W-3:0]];
    logic [`AXI_ADDR_W-1:0] aw_addr;
    logic [`AXI_DATA_W-1:0] w_data;
    logic [`AXI_STRB_W-1:0] w_strb;
    logic                   have_aw;
    logic                   have_w;
    integer                 seed;

    initial begin
        seed    = 32'hffca_69fc;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = RESP_OKAY;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = RESP_OKAY;
    end

    function automatic logic [`AXI_DATA_W-1:0] word_at(input logic [`AXI_ADDR_W-1:0] addr);
        if (mem.exists(addr[`AXI_ADDR_W-1:2])) begin
            return mem[addr[`AXI_ADDR_W-1:2]];
        end
        return {addr[`AXI_ADDR_W-1:2], 2'b00} ^ 32'h3c5a_96e1;  // Unwritten word
    endfunction

    function automatic logic [`AXI_DATA_W-1:0] merge_bytes(input logic [`AXI_DATA_W-1:0] old,
            input logic [`AXI_DATA_W-1:0] data, input logic [`AXI_STRB_W-1:0] strb);
        logic [`AXI_DATA_W-1:0] result;
        result = old;
        for (int i = 0; i < `AXI_STRB_W; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = data[8*i +: 8];
            end
        end
        return result;
    endfunction

    // One in four chance per cycle
    function automatic logic coin();
        return ($random(seed) & 3) == 0;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            have_aw <= 1'b0;
            have_w  <= 1'b0;
            touched <= 1'b0;
        end else begin
            if (touch_clear) begin
                touched <= 1'b0;
            end else if (arvalid || awvalid || wvalid) begin
                touched <= 1'b1;
            end

            if (arvalid && arready) begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
                rdata   <= word_at(araddr);
                rresp   <= RESP_OKAY;
            end else begin
                arready <= arvalid && !rvalid && coin();
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end

            if (awvalid && awready) begin
                awready <= 1'b0;
                have_aw <= 1'b1;
                aw_addr <= awaddr;
            end else begin
                awready <= awvalid && !have_aw && !bvalid && coin();
            end
            if (wvalid && wready) begin
                wready <= 1'b0;
                have_w <= 1'b1;
                w_data <= wdata;
                w_strb <= wstrb;
            end else begin
                wready <= wvalid && !have_w && !bvalid && coin();
            end

            if (have_aw && have_w) begin
                have_aw <= 1'b0;
                have_w  <= 1'b0;
                bvalid  <= 1'b1;
                if (IS_UART && aw_addr[2:0] == STATUS_OFS) begin
                    bresp <= RESP_SLVERR;
                end else begin
                    bresp <= RESP_OKAY;
                    mem[aw_addr[`AXI_ADDR_W-1:2]] = merge_bytes(word_at(aw_addr), w_data, w_strb);
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_arb_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_arb_settings.svh"

module axi_arb_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`AXI_ADDR_W-1:0] ifu_araddr,
    input  logic                   ifu_arvalid,
    output logic                   ifu_arready,
    output logic [`AXI_DATA_W-1:0] ifu_rdata,
    output logic [1:0]             ifu_rresp,
    output logic                   ifu_rvalid,
    input  logic                   ifu_rready,
    input  logic [`AXI_ADDR_W-1:0] lsu_araddr,
    input  logic                   lsu_arvalid,
    output logic                   lsu_arready,
    output logic [`AXI_DATA_W-1:0] lsu_rdata,
    output logic [1:0]             lsu_rresp,
    output logic                   lsu_rvalid,
    input  logic                   lsu_rready,
    input  logic [`AXI_ADDR_W-1:0] lsu_awaddr,
    input  logic                   lsu_awvalid,
    output logic                   lsu_awready,
    input  logic [`AXI_DATA_W-1:0] lsu_wdata,
    input  logic [`AXI_STRB_W-1:0] lsu_wstrb,
    input  logic                   lsu_wvalid,
    output logic                   lsu_wready,
    output logic [1:0]             lsu_bresp,
    output logic                   lsu_bvalid,
    input  logic                   lsu_bready,
    output logic [`AXI_ADDR_W-1:0] sram_araddr,
    output logic                   sram_arvalid,
    input  logic                   sram_arready,
    input  logic [`AXI_DATA_W-1:0] sram_rdata,
    input  logic [1:0]             sram_rresp,
    input  logic                   sram_rvalid,
    output logic                   sram_rready,
    output logic [`AXI_ADDR_W-1:0] sram_awaddr,
    output logic                   sram_awvalid,
    input  logic                   sram_awready,
    output logic [`AXI_DATA_W-1:0] sram_wdata,
    output logic [`AXI_STRB_W-1:0] sram_wstrb,
    output logic                   sram_wvalid,
    input  logic                   sram_wready,
    input  logic [1:0]             sram_bresp,
    input  logic                   sram_bvalid,
    output logic                   sram_bready,
    output logic [`AXI_ADDR_W-1:0] uart_araddr,
    output logic                   uart_arvalid,
    input  logic                   uart_arready,
    input  logic [`AXI_DATA_W-1:0] uart_rdata,
    input  logic [1:0]             uart_rresp,
    input  logic                   uart_rvalid,
    output logic                   uart_rready,
    output logic [`AXI_ADDR_W-1:0] uart_awaddr,
    output logic                   uart_awvalid,
    input  logic                   uart_awready,
    output logic [`AXI_DATA_W-1:0] uart_wdata,
    output logic [`AXI_STRB_W-1:0] uart_wstrb,
    output logic                   uart_wvalid,
    input  logic                   uart_wready,
    input  logic [1:0]             uart_bresp,
    input  logic                   uart_bvalid,
    output logic                   uart_bready
);
    import axi_arb_pkg::*;

    owner_t  owner;
    target_t target;
    logic    read_done;
    logic    write_done;

    // Ports match by name throughout
    grant_fsm grant_fsm_i (.*);

    read_router read_router_i (.*);

    write_router write_router_i (.*);

endmodule

`default_nettype wire

//--- router/write_router.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_arb_settings.svh"

module write_router (
    input  logic                   clk,
    input  logic                   reset,
    input  axi_arb_pkg::owner_t    owner,
    input  axi_arb_pkg::target_t   target,
    input  logic [`AXI_ADDR_W-1:0] lsu_awaddr,
    input  logic                   lsu_awvalid,
    input  logic [`AXI_DATA_W-1:0] lsu_wdata,
    input  logic [`AXI_STRB_W-1:0] lsu_wstrb,
    input  logic                   lsu_wvalid,
    input  logic                   lsu_bready,
    input  logic                   sram_awready,
    input  logic                   sram_wready,
    input  logic [1:0]             sram_bresp,
    input  logic                   sram_bvalid,
    input  logic                   uart_awready,
    input  logic                   uart_wready,
    input  logic [1:0]             uart_bresp,
    input  logic                   uart_bvalid,
    output logic                   lsu_awready,
    output logic                   lsu_wready,
    output logic [1:0]             lsu_bresp,
    output logic                   lsu_bvalid,
    output logic [`AXI_ADDR_W-1:0] sram_awaddr,
    output logic                   sram_awvalid,
    output logic [`AXI_DATA_W-1:0] sram_wdata,
    output logic [`AXI_STRB_W-1:0] sram_wstrb,
    output logic                   sram_wvalid,
    output logic                   sram_bready,
    output logic [`AXI_ADDR_W-1:0] uart_awaddr,
    output logic                   uart_awvalid,
    output logic [`AXI_DATA_W-1:0] uart_wdata,
    output logic [`AXI_STRB_W-1:0] uart_wstrb,
    output logic                   uart_wvalid,
    output logic                   uart_bready,
    output logic                   write_done
);
    import axi_arb_pkg::*;

    logic       sel_wr;
    logic       sel_sram;
    logic       sel_uart;
    logic       sel_err;
    logic       m_awready;
    logic       m_wready;
    logic [1:0] m_bresp;
    logic       m_bvalid;
    logic       err_aw_taken;
    logic       err_w_taken;

    assign sel_wr   = (owner == OWNER_LSU_WR);
    assign sel_sram = sel_wr && (target == TGT_SRAM);
    assign sel_uart = sel_wr && (target == TGT_UART);
    assign sel_err  = sel_wr && (target == TGT_ERR);

    assign sram_awaddr  = sel_sram ? lsu_awaddr : '0;
    assign sram_awvalid = sel_sram & lsu_awvalid;
    assign sram_wdata   = sel_sram ? lsu_wdata : '0;
    assign sram_wstrb   = sel_sram ? lsu_wstrb : '0;
    assign sram_wvalid  = sel_sram & lsu_wvalid;
    assign sram_bready  = sel_sram & lsu_bready;

    assign uart_awaddr  = sel_uart ? lsu_awaddr : '0;
    assign uart_awvalid = sel_uart & lsu_awvalid;
    assign uart_wdata   = sel_uart ? lsu_wdata : '0;
    assign uart_wstrb   = sel_uart ? lsu_wstrb : '0;
    assign uart_wvalid  = sel_uart & lsu_wvalid;
    assign uart_bready  = sel_uart & lsu_bready;

    always_comb begin
        case (target)
            TGT_SRAM: begin
                m_awready = sram_awready;
                m_wready  = sram_wready;
                m_bresp   = sram_bresp;
                m_bvalid  = sram_bvalid;
            end
            TGT_UART: begin
                m_awready = uart_awready;
                m_wready  = uart_wready;
                m_bresp   = uart_bresp;
                m_bvalid  = uart_bvalid;
            end
            default: begin
                m_awready = !err_aw_taken;  // AW and W each taken once
                m_wready  = !err_w_taken;
                m_bresp   = RESP_DECERR;
                m_bvalid  = err_aw_taken & err_w_taken;
            end
        endcase
    end

    assign lsu_awready = sel_wr & m_awready;
    assign lsu_wready  = sel_wr & m_wready;
    assign lsu_bresp   = sel_wr ? m_bresp : 2'b00;
    assign lsu_bvalid  = sel_wr & m_bvalid;

    assign write_done = lsu_bvalid & lsu_bready;

    always_ff @(posedge clk) begin
        if (reset) begin
            err_aw_taken <= 1'b0;
            err_w_taken  <= 1'b0;
        end else if (write_done) begin
            err_aw_taken <= 1'b0;
            err_w_taken  <= 1'b0;
        end else begin
            if (sel_err && lsu_awvalid && lsu_awready) begin
                err_aw_taken <= 1'b1;
            end
            if (sel_err && lsu_wvalid && lsu_wready) begin
                err_w_taken <= 1'b1;
            end
        end
    end

    // DECERR state only inside an unmapped write grant
    a_err_state: assert property (@(posedge clk) disable iff (reset)
        (err_aw_taken || err_w_taken) |-> sel_err);

endmodule

`default_nettype wire

//--- router/read_router.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_arb_settings.svh"

module read_router (
    input  logic                   clk,
    input  logic                   reset,
    input  axi_arb_pkg::owner_t    owner,
    input  axi_arb_pkg::target_t   target,
    input  logic [`AXI_ADDR_W-1:0] ifu_araddr,
    input  logic                   ifu_arvalid,
    input  logic                   ifu_rready,
    input  logic [`AXI_ADDR_W-1:0] lsu_araddr,
    input  logic                   lsu_arvalid,
    input  logic                   lsu_rready,
    input  logic                   sram_arready,
    input  logic [`AXI_DATA_W-1:0] sram_rdata,
    input  logic [1:0]             sram_rresp,
    input  logic                   sram_rvalid,
    input  logic                   uart_arready,
    input  logic [`AXI_DATA_W-1:0] uart_rdata,
    input  logic [1:0]             uart_rresp,
    input  logic                   uart_rvalid,
    output logic                   ifu_arready,
    output logic [`AXI_DATA_W-1:0] ifu_rdata,
    output logic [1:0]             ifu_rresp,
    output logic                   ifu_rvalid,
    output logic                   lsu_arready,
    output logic [`AXI_DATA_W-1:0] lsu_rdata,
    output logic [1:0]             lsu_rresp,
    output logic                   lsu_rvalid,
    output logic [`AXI_ADDR_W-1:0] sram_araddr,
    output logic                   sram_arvalid,
    output logic                   sram_rready,
    output logic [`AXI_ADDR_W-1:0] uart_araddr,
    output logic                   uart_arvalid,
    output logic                   uart_rready,
    output logic                   read_done
);
    import axi_arb_pkg::*;

    logic                   sel_ifu;
    logic                   sel_lsu;
    logic                   sel_sram;
    logic                   sel_uart;
    logic [`AXI_ADDR_W-1:0] m_araddr;
    logic                   m_arvalid;
    logic                   m_arready;
    logic [`AXI_DATA_W-1:0] m_rdata;
    logic [1:0]             m_rresp;
    logic                   m_rvalid;
    logic                   m_rready;
    logic                   err_ar_taken;  // DECERR responder holds R

    assign sel_ifu  = (owner == OWNER_IFU);
    assign sel_lsu  = (owner == OWNER_LSU_RD);
    assign sel_sram = (sel_ifu | sel_lsu) && (target == TGT_SRAM);
    assign sel_uart = (sel_ifu | sel_lsu) && (target == TGT_UART);

    assign m_araddr  = sel_ifu ? ifu_araddr : lsu_araddr;
    assign m_arvalid = (sel_ifu & ifu_arvalid) | (sel_lsu & lsu_arvalid);
    assign m_rready  = (sel_ifu & ifu_rready) | (sel_lsu & lsu_rready);

    assign sram_araddr  = sel_sram ? m_araddr : '0;
    assign sram_arvalid = sel_sram & m_arvalid;
    assign sram_rready  = sel_sram & m_rready;
    assign uart_araddr  = sel_uart ? m_araddr : '0;
    assign uart_arvalid = sel_uart & m_arvalid;
    assign uart_rready  = sel_uart & m_rready;

    always_comb begin
        case (target)
            TGT_SRAM: begin
                m_arready = sram_arready;
                m_rdata   = sram_rdata;
                m_rresp   = sram_rresp;
                m_rvalid  = sram_rvalid;
            end
            TGT_UART: begin
                m_arready = uart_arready;
                m_rdata   = uart_rdata;
                m_rresp   = uart_rresp;
                m_rvalid  = uart_rvalid;
            end
            default: begin
                m_arready = !err_ar_taken;  // Take AR once
                m_rdata   = '0;
                m_rresp   = RESP_DECERR;
                m_rvalid  = err_ar_taken;
            end
        endcase
    end

    assign ifu_arready = sel_ifu & m_arready;
    assign ifu_rdata   = sel_ifu ? m_rdata : '0;
    assign ifu_rresp   = sel_ifu ? m_rresp : 2'b00;
    assign ifu_rvalid  = sel_ifu & m_rvalid;
    assign lsu_arready = sel_lsu & m_arready;
    assign lsu_rdata   = sel_lsu ? m_rdata : '0;
    assign lsu_rresp   = sel_lsu ? m_rresp : 2'b00;
    assign lsu_rvalid  = sel_lsu & m_rvalid;

    assign read_done = m_rvalid & m_rready;

    always_ff @(posedge clk) begin
        if (reset) begin
            err_ar_taken <= 1'b0;
        end else if (read_done) begin
            err_ar_taken <= 1'b0;
        end else if (target == TGT_ERR && m_arvalid && m_arready) begin
            err_ar_taken <= 1'b1;
        end
    end

    // Forwarded AR stays up until taken
    a_ar_hold: assert property (@(posedge clk) disable iff (reset)
        (m_arvalid && !m_arready) |=> m_arvalid);

    // DECERR state only inside an unmapped read grant
    a_err_state: assert property (@(posedge clk) disable iff (reset)
        err_ar_taken |-> ((sel_ifu || sel_lsu) && target == TGT_ERR));

endmodule

`default_nettype wire

//--- arbiter/grant_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_arb_settings.svh"

module grant_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`AXI_ADDR_W-1:0] ifu_araddr,
    input  logic                   ifu_arvalid,
    input  logic [`AXI_ADDR_W-1:0] lsu_araddr,
    input  logic                   lsu_arvalid,
    input  logic [`AXI_ADDR_W-1:0] lsu_awaddr,
    input  logic                   lsu_awvalid,
    input  logic                   read_done,
    input  logic                   write_done,
    output axi_arb_pkg::owner_t    owner,
    output axi_arb_pkg::target_t   target
);
    import axi_arb_pkg::*;

    owner_t  owner_next;
    target_t target_next;
    logic    owner_done;

    function automatic target_t decode(input logic [`AXI_ADDR_W-1:0] addr);
        if (addr >= `SRAM_BASE && addr <= `SRAM_LAST) begin
            return TGT_SRAM;
        end else if (addr >= `UART_BASE && addr <= `UART_LAST) begin
            return TGT_UART;
        end
        return TGT_ERR;
    endfunction

    always_comb begin
        case (owner)
            OWNER_IFU, OWNER_LSU_RD: owner_done = read_done;
            OWNER_LSU_WR:            owner_done = write_done;
            default:                 owner_done = 1'b0;
        endcase
    end

    // Fixed priority with one decode at grant
    always_comb begin
        owner_next  = owner;
        target_next = target;
        if (owner == OWNER_NONE) begin
            if (lsu_awvalid) begin
                owner_next  = OWNER_LSU_WR;
                target_next = decode(lsu_awaddr);
            end else if (lsu_arvalid) begin
                owner_next  = OWNER_LSU_RD;
                target_next = decode(lsu_araddr);
            end else if (ifu_arvalid) begin
                owner_next  = OWNER_IFU;
                target_next = decode(ifu_araddr);
            end
        end else if (owner_done) begin
            owner_next = OWNER_NONE;  // Target kept until next grant
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            owner  <= OWNER_NONE;
            target <= TGT_ERR;
        end else begin
            owner  <= owner_next;
            target <= target_next;
        end
    end

    // Done only from the current owner
    a_done_owner: assert property (@(posedge clk) disable iff (reset)
        (read_done || write_done) |-> owner_done);

    // Pending write address still decodes to the registered target
    a_target_match: assert property (@(posedge clk) disable iff (reset)
        (owner == OWNER_LSU_WR && lsu_awvalid) |-> (target == decode(lsu_awaddr)));

endmodule

`default_nettype wire

//--- common/axi_arb_pkg.sv
`default_nettype none

package axi_arb_pkg;

    typedef enum logic [1:0] {
        OWNER_NONE   = 2'd0,
        OWNER_IFU    = 2'd1,
        OWNER_LSU_RD = 2'd2,
        OWNER_LSU_WR = 2'd3
    } owner_t;

    typedef enum logic [1:0] {
        TGT_SRAM = 2'd0,
        TGT_UART = 2'd1,
        TGT_ERR  = 2'd2  // Answered inside the arbiter
    } target_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

endpackage

`default_nettype wire

//--- common/axi_arb_settings.svh
`ifndef AXI_ARB_SETTINGS_SVH
`define AXI_ARB_SETTINGS_SVH

`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W 4  // One strobe per data byte

// Address windows, both ends inclusive
`define SRAM_BASE 32'h8000_0000
`define SRAM_LAST 32'h87ff_ffff

`define UART_BASE 32'ha000_0000
`define UART_LAST 32'ha000_0007  // Data at 0, status at 4

`endif
